//--- include/cache_dma_defines.svh
`ifndef CACHE_DMA_DEFINES_SVH
`define CACHE_DMA_DEFINES_SVH

// byte address and cache word widths
`define CDMA_ADDR_WIDTH 32
`define CDMA_WORD_WIDTH 32

// one memory-side burst is two words
`define CDMA_DMA_WIDTH 64
`define CDMA_BURST_BYTES 8

// block geometry, 8 words carried as 4 bursts
`define CDMA_BLOCK_BURSTS 4
`define CDMA_BLOCK_WORDS 8
`define CDMA_BLOCK_OFFSET 5

// miss status holding registers
`define CDMA_MSHR_ELS 4
`define CDMA_MSHR_ID_WIDTH 2

// burst counter must reach the full block count, so 0 to 4
`define CDMA_CNT_WIDTH 3

`endif

//--- src/cache_geom_pkg.sv
`include "cache_dma_defines.svh"

package cache_geom_pkg;

  typedef logic [`CDMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CDMA_MSHR_ID_WIDTH-1:0] mshr_id_t;
  // one bit per mshr, used for one-hot done and enqueue flags
  typedef logic [`CDMA_MSHR_ELS-1:0] mshr_vec_t;

  typedef logic [`CDMA_DMA_WIDTH-1:0] burst_t;
  typedef logic [`CDMA_BURST_BYTES-1:0] burst_mask_t;

  // whole block of mshr write data and its byte mask
  typedef logic [`CDMA_BLOCK_BURSTS*`CDMA_DMA_WIDTH-1:0] block_t;
  typedef logic [`CDMA_BLOCK_BURSTS*`CDMA_BURST_BYTES-1:0] block_mask_t;

  typedef logic [`CDMA_CNT_WIDTH-1:0] burst_cnt_t;
  typedef logic [`CDMA_WORD_WIDTH/8-1:0] word_mask_t;

endpackage

//--- src/dma_msg_pkg.sv
`include "cache_dma_defines.svh"

package dma_msg_pkg;

  import cache_geom_pkg::*;

  // command from the miss handling unit
  typedef enum logic [1:0] {
    dma_nop,
    dma_send_refill_addr,
    dma_send_evict_addr
  } dma_cmd_e;

  // request packet toward memory
  // mask has one bit per word of the block, only used by evicts
  typedef struct packed {
    logic write_not_read;
    addr_t addr;
    logic [`CDMA_BLOCK_WORDS-1:0] mask;
    mshr_id_t mshr_id;
  } dma_pkt_s;

endpackage

//--- src/dma_done_if.sv
`timescale 1ns/1ps

interface dma_done_if
  import cache_geom_pkg::*;
();

  // single-cycle completion pulses, each id valid with its pulse
  logic refill_done;
  mshr_id_t refill_id;
  logic evict_done;
  mshr_id_t evict_id;

  // refill path owns the refill fields, evict path the evict fields
  modport source (output refill_done, output refill_id, output evict_done, output evict_id);

  // command controller folds both events into the done bus
  modport sink (input refill_done, input refill_id, input evict_done, input evict_id);

endinterface

//--- src/dma_burst_fifo.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module dma_burst_fifo
  import cache_geom_pkg::*;
#(
  parameter int depth_p = `CDMA_BLOCK_BURSTS
) (
  input  logic   clk_i,
  input  logic   reset_i,
  input  burst_t data_i,
  input  logic   v_i,
  output logic   ready_o,
  output burst_t data_o,
  output logic   v_o,
  input  logic   yumi_i
);

  localparam int ptr_width_lp = $clog2(depth_p);
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] cnt_t;

  localparam ptr_t last_ptr_lp = ptr_t'(depth_p - 1);
  localparam cnt_t full_cnt_lp = cnt_t'(depth_p);

  burst_t mem_r [depth_p];
  ptr_t   wr_ptr_r;
  ptr_t   rd_ptr_r;
  cnt_t   count_r;
  logic   enq;
  logic   deq;

  // no bypass, so a write shows at the output one cycle later
  assign ready_o = (count_r != full_cnt_lp);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  // storage array
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // pointers wrap at the last slot, depth need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      end
      // occupancy holds when both sides move together
      if (enq & ~deq) begin
        count_r <= count_r + 1'b1;
      end else if (deq & ~enq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

//--- src/dma_cmd_ctrl.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module dma_cmd_ctrl
  import cache_geom_pkg::*;
  import dma_msg_pkg::*;
(
  input  dma_cmd_e                     cmd_i,
  input  addr_t                        req_addr_i,
  input  mshr_id_t                     req_mshr_id_i,
  input  logic [`CDMA_BLOCK_WORDS-1:0] evict_word_mask_i,
  output dma_pkt_s                     dma_pkt_o,
  output logic                         dma_pkt_v_o,
  input  logic                         dma_pkt_yumi_i,
  dma_done_if.sink                     done,
  output mshr_vec_t                    mhu_dma_done_o
);

  logic req_done;

  // packet is formed in the same cycle as the command
  always_comb begin
    dma_pkt_v_o              = 1'b0;
    dma_pkt_o.write_not_read = 1'b0;
    // clear the offset bits so the request is block aligned
    dma_pkt_o.addr = {req_addr_i[`CDMA_ADDR_WIDTH-1:`CDMA_BLOCK_OFFSET],
                      {`CDMA_BLOCK_OFFSET{1'b0}}};
    dma_pkt_o.mask           = '0;
    dma_pkt_o.mshr_id        = req_mshr_id_i;
    case (cmd_i)
      dma_send_refill_addr: begin
        dma_pkt_v_o = 1'b1;
      end
      dma_send_evict_addr: begin
        dma_pkt_v_o              = 1'b1;
        dma_pkt_o.write_not_read = 1'b1;
        // only the words that are written back
        dma_pkt_o.mask           = evict_word_mask_i;
      end
      default: begin
        dma_pkt_v_o = 1'b0;
      end
    endcase
  end

  // request completes when memory takes the packet
  assign req_done = dma_pkt_v_o & dma_pkt_yumi_i;

  // fold request, refill and evict completions into one-hot per mshr
  always_comb begin
    for (int i = 0; i < `CDMA_MSHR_ELS; i++) begin
      mhu_dma_done_o[i] = (req_done & (req_mshr_id_i == mshr_id_t'(i)))
                        | (done.refill_done & (done.refill_id == mshr_id_t'(i)))
                        | (done.evict_done & (done.evict_id == mshr_id_t'(i)));
    end
  end

endmodule

//--- src/refill_path.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module refill_path
  import cache_geom_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  burst_t      dma_data_i,
  input  mshr_id_t    dma_refill_mshr_id_i,
  input  logic        dma_data_v_i,
  output logic        dma_data_ready_o,
  input  block_t      mshr_data_i,
  input  block_mask_t mshr_data_byte_mask_i,
  output logic        mshr_cam_r_v_o,
  input  mshr_vec_t   evict_enqueued_i,
  output burst_t      fill_data_o,
  output logic        fill_v_o,
  input  logic        fill_ready_i,
  input  logic        fill_done_i,
  output mshr_id_t    refill_mshr_id_o,
  dma_done_if.source  done
);

  localparam int sel_width_lp = $clog2(`CDMA_BLOCK_BURSTS);
  localparam burst_cnt_t block_bursts_lp = burst_cnt_t'(`CDMA_BLOCK_BURSTS);

  logic        fifo_v_li;
  logic        fifo_ready_lo;
  logic        fifo_v_lo;
  burst_t      fifo_data_lo;
  logic        fifo_yumi_li;
  burst_cnt_t  in_cnt_r;
  burst_cnt_t  out_cnt_r;
  logic        in_max;
  logic        in_up;
  mshr_id_t    id_r;
  block_t      mshr_data_r;
  block_mask_t mshr_mask_r;
  burst_t      mshr_burst;
  burst_mask_t mshr_burst_mask;
  logic        fill_done_r;
  logic        refill_done;

  // stop taking memory data once the whole block is in
  assign in_max           = (in_cnt_r == block_bursts_lp);
  assign fifo_v_li        = dma_data_v_i & ~in_max;
  assign dma_data_ready_o = fifo_ready_lo & ~in_max;
  assign in_up            = dma_data_v_i & dma_data_ready_o;

  // first burst of a block reads the mshr cam
  assign mshr_cam_r_v_o = in_up & (in_cnt_r == '0);

  dma_burst_fifo #(
    .depth_p(`CDMA_BLOCK_BURSTS)
  ) in_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (dma_data_i),
    .v_i    (fifo_v_li),
    .ready_o(fifo_ready_lo),
    .data_o (fifo_data_lo),
    .v_o    (fifo_v_lo),
    .yumi_i (fifo_yumi_li)
  );

  // slice of mshr data lined up with the burst leaving the fifo
  assign mshr_burst      = mshr_data_r[out_cnt_r[sel_width_lp-1:0]*`CDMA_DMA_WIDTH +: `CDMA_DMA_WIDTH];
  assign mshr_burst_mask = mshr_mask_r[out_cnt_r[sel_width_lp-1:0]*`CDMA_BURST_BYTES +: `CDMA_BURST_BYTES];

  // bytes already stored in the mshr take priority over memory
  always_comb begin
    for (int b = 0; b < `CDMA_BURST_BYTES; b++) begin
      fill_data_o[b*8 +: 8] = mshr_burst_mask[b] ? mshr_burst[b*8 +: 8] : fifo_data_lo[b*8 +: 8];
    end
  end

  // old line must be queued for eviction before new data may overwrite it
  assign fill_v_o     = fifo_v_lo & evict_enqueued_i[id_r];
  assign fifo_yumi_li = fill_v_o & fill_ready_i;

  // fill done may arrive early, so it is held until the block is in
  assign refill_done = in_max & (fill_done_r | fill_done_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_cnt_r    <= '0;
      out_cnt_r   <= '0;
      fill_done_r <= 1'b0;
      id_r        <= '0;
    end else if (refill_done) begin
      in_cnt_r    <= '0;
      out_cnt_r   <= '0;
      fill_done_r <= 1'b0;
    end else begin
      if (in_up) begin
        in_cnt_r <= in_cnt_r + 1'b1;
      end
      if (fifo_yumi_li) begin
        out_cnt_r <= out_cnt_r + 1'b1;
      end
      if (fill_done_i) begin
        fill_done_r <= 1'b1;
      end
      if (mshr_cam_r_v_o) begin
        id_r <= dma_refill_mshr_id_i;
      end
    end
  end

  // mshr snapshot taken with the cam read
  always_ff @(posedge clk_i) begin
    if (mshr_cam_r_v_o) begin
      mshr_data_r <= mshr_data_i;
      mshr_mask_r <= mshr_data_byte_mask_i;
    end
  end

  assign refill_mshr_id_o = id_r;
  assign done.refill_done = refill_done;
  assign done.refill_id   = id_r;

endmodule

//--- src/evict_path.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module evict_path
  import cache_geom_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  burst_t     evict_data_i,
  input  logic       evict_v_i,
  output logic       evict_yumi_o,
  input  mshr_id_t   evict_mshr_id_i,
  output burst_t     dma_data_o,
  output logic       dma_data_v_o,
  input  logic       dma_data_yumi_i,
  dma_done_if.source done
);

  localparam burst_cnt_t block_bursts_lp = burst_cnt_t'(`CDMA_BLOCK_BURSTS);

  logic       fifo_ready_lo;
  logic       fifo_v_lo;
  logic       fifo_yumi_li;
  burst_cnt_t cnt_r;
  logic       cnt_max;
  mshr_id_t   id_r;
  logic       evict_done;

  // take evicted bursts until one full block has been collected
  assign cnt_max      = (cnt_r == block_bursts_lp);
  assign evict_yumi_o = evict_v_i & fifo_ready_lo & ~cnt_max;

  dma_burst_fifo #(
    .depth_p(`CDMA_BLOCK_BURSTS)
  ) out_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (evict_data_i),
    .v_i    (evict_yumi_o),
    .ready_o(fifo_ready_lo),
    .data_o (dma_data_o),
    .v_o    (fifo_v_lo),
    .yumi_i (fifo_yumi_li)
  );

  // memory sees nothing until the whole block is buffered
  assign dma_data_v_o = fifo_v_lo & cnt_max;
  assign fifo_yumi_li = dma_data_yumi_i & dma_data_v_o;

  // block drained, fires the cycle after the last yumi
  assign evict_done = cnt_max & ~fifo_v_lo;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
      id_r  <= '0;
    end else if (evict_done) begin
      cnt_r <= '0;
    end else if (evict_yumi_o) begin
      cnt_r <= cnt_r + 1'b1;
      // id travels with the first burst only
      if (cnt_r == '0) begin
        id_r <= evict_mshr_id_i;
      end
    end
  end

  assign done.evict_done = evict_done;
  assign done.evict_id   = id_r;

endmodule

//--- src/cache_dma.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module cache_dma
  import cache_geom_pkg::*;
  import dma_msg_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  // request command from the miss handling unit
  input  dma_cmd_e                     cmd_i,
  input  addr_t                        req_addr_i,
  input  mshr_id_t                     req_mshr_id_i,
  input  logic [`CDMA_BLOCK_WORDS-1:0] evict_word_mask_i,
  output dma_pkt_s                     dma_pkt_o,
  output logic                         dma_pkt_v_o,
  input  logic                         dma_pkt_yumi_i,
  // refill data from memory
  input  burst_t                       dma_data_i,
  input  mshr_id_t                     dma_refill_mshr_id_i,
  input  logic                         dma_data_v_i,
  output logic                         dma_data_ready_o,
  input  block_t                       mshr_data_i,
  input  block_mask_t                  mshr_data_byte_mask_i,
  output logic                         mshr_cam_r_v_o,
  input  mshr_vec_t                    evict_enqueued_i,
  // merged refill toward the fill writer
  output burst_t                       fill_data_o,
  output logic                         fill_v_o,
  input  logic                         fill_ready_i,
  input  logic                         fill_done_i,
  output mshr_id_t                     refill_mshr_id_o,
  // evicted block in from the cache, out to memory
  input  burst_t                       evict_data_i,
  input  logic                         evict_v_i,
  output logic                         evict_yumi_o,
  input  mshr_id_t                     evict_mshr_id_i,
  output burst_t                       dma_data_o,
  output logic                         dma_data_v_o,
  input  logic                         dma_data_yumi_i,
  // one-hot completion per mshr
  output mshr_vec_t                    mhu_dma_done_o
);

  dma_done_if done_if ();

  dma_cmd_ctrl cmd_ctrl (
    .cmd_i            (cmd_i),
    .req_addr_i       (req_addr_i),
    .req_mshr_id_i    (req_mshr_id_i),
    .evict_word_mask_i(evict_word_mask_i),
    .dma_pkt_o        (dma_pkt_o),
    .dma_pkt_v_o      (dma_pkt_v_o),
    .dma_pkt_yumi_i   (dma_pkt_yumi_i),
    .done             (done_if),
    .mhu_dma_done_o   (mhu_dma_done_o)
  );

  refill_path refill (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .dma_data_i           (dma_data_i),
    .dma_refill_mshr_id_i (dma_refill_mshr_id_i),
    .dma_data_v_i         (dma_data_v_i),
    .dma_data_ready_o     (dma_data_ready_o),
    .mshr_data_i          (mshr_data_i),
    .mshr_data_byte_mask_i(mshr_data_byte_mask_i),
    .mshr_cam_r_v_o       (mshr_cam_r_v_o),
    .evict_enqueued_i     (evict_enqueued_i),
    .fill_data_o          (fill_data_o),
    .fill_v_o             (fill_v_o),
    .fill_ready_i         (fill_ready_i),
    .fill_done_i          (fill_done_i),
    .refill_mshr_id_o     (refill_mshr_id_o),
    .done                 (done_if)
  );

  evict_path evict (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .evict_data_i   (evict_data_i),
    .evict_v_i      (evict_v_i),
    .evict_yumi_o   (evict_yumi_o),
    .evict_mshr_id_i(evict_mshr_id_i),
    .dma_data_o     (dma_data_o),
    .dma_data_v_o   (dma_data_v_o),
    .dma_data_yumi_i(dma_data_yumi_i),
    .done           (done_if)
  );

endmodule

//--- verification/tb_cache_dma.sv
`timescale 1ns/1ps
`include "cache_dma_defines.svh"

module tb_cache_dma
  import cache_geom_pkg::*;
  import dma_msg_pkg::*;
();

  logic clk_i;
  logic reset_i;
  dma_cmd_e cmd_i;
  addr_t req_addr_i;
  mshr_id_t req_mshr_id_i;
  logic [`CDMA_BLOCK_WORDS-1:0] evict_word_mask_i;
  dma_pkt_s dma_pkt_o;
  logic dma_pkt_v_o;
  logic dma_pkt_yumi_i;
  burst_t dma_data_i;
  mshr_id_t dma_refill_mshr_id_i;
  logic dma_data_v_i;
  logic dma_data_ready_o;
  block_t mshr_data_i;
  block_mask_t mshr_data_byte_mask_i;
  logic mshr_cam_r_v_o;
  mshr_vec_t evict_enqueued_i;
  burst_t fill_data_o;
  logic fill_v_o;
  logic fill_ready_i;
  logic fill_done_i;
  mshr_id_t refill_mshr_id_o;
  burst_t evict_data_i;
  logic evict_v_i;
  logic evict_yumi_o;
  mshr_id_t evict_mshr_id_i;
  burst_t dma_data_o;
  logic dma_data_v_o;
  logic dma_data_yumi_i;
  mshr_vec_t mhu_dma_done_o;

  // lfsr state and the model's copy of the mshr contents
  logic [15:0] lfsr_q;
  block_t mshr_copy;
  block_mask_t mask_copy;
  int err_cnt;
  int test_err_base;
  int tests_run;
  int tests_failed;

  cache_dma dut0 (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) r = {r[62:0], rand_bit()};
    return r;
  endfunction

  function automatic block_t rand_block();
    block_t r;
    int k;
    for (k = 0; k < `CDMA_BLOCK_BURSTS; k++) r[k*64 +: 64] = rand_bits(64);
    return r;
  endfunction

  function automatic mshr_vec_t onehot(input mshr_id_t id);
    return mshr_vec_t'(1) << id;
  endfunction

  // expected fill burst k where a set mask bit picks the mshr byte
  function automatic burst_t merge_burst(input burst_t mem, input int k);
    burst_t r;
    int b;
    for (b = 0; b < `CDMA_BURST_BYTES; b++) begin
      r[b*8 +: 8] = mask_copy[k*8+b] ? mshr_copy[(k*8+b)*8 +: 8] : mem[b*8 +: 8];
    end
    return r;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != test_err_base) tests_failed++;
    $display("test %s: %s", name, (err_cnt == test_err_base) ? "ok" : "failed");
    test_err_base = err_cnt;
  endtask

  task automatic check_reset();
    @(negedge clk_i);
    if (dma_pkt_v_o !== 1'b0) report_mismatch("dma_pkt_v_o", 64'(dma_pkt_v_o), 64'(0));
    if (fill_v_o !== 1'b0) report_mismatch("fill_v_o", 64'(fill_v_o), 64'(0));
    if (dma_data_v_o !== 1'b0) report_mismatch("dma_data_v_o", 64'(dma_data_v_o), 64'(0));
    if (evict_yumi_o !== 1'b0) report_mismatch("evict_yumi_o", 64'(evict_yumi_o), 64'(0));
    if (mshr_cam_r_v_o !== 1'b0) report_mismatch("mshr_cam_r_v_o", 64'(mshr_cam_r_v_o), 64'(0));
    if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
    if (dma_data_ready_o !== 1'b1) begin
      report_mismatch("dma_data_ready_o", 64'(dma_data_ready_o), 64'(1));
    end
    end_test("reset state");
  endtask

  // one command held a cycle without yumi, then taken and followed by a nop
  task automatic run_cmd(input dma_cmd_e cmd, input string name);
    addr_t addr;
    mshr_id_t id;
    logic [`CDMA_BLOCK_WORDS-1:0] wmask;
    logic is_evict;
    addr = addr_t'(rand_bits(32));
    id = mshr_id_t'(rand_bits(2));
    wmask = 8'(rand_bits(8));
    is_evict = (cmd == dma_send_evict_addr);
    @(posedge clk_i);
    cmd_i <= cmd;
    req_addr_i <= addr;
    req_mshr_id_i <= id;
    evict_word_mask_i <= wmask;
    dma_pkt_yumi_i <= 1'b0;
    @(negedge clk_i);
    if (dma_pkt_v_o !== 1'b1) report_mismatch("dma_pkt_v_o", 64'(dma_pkt_v_o), 64'(1));
    if (dma_pkt_o.write_not_read !== is_evict) begin
      report_mismatch("write_not_read", 64'(dma_pkt_o.write_not_read), 64'(is_evict));
    end
    if (dma_pkt_o.addr !== {addr[31:5], 5'b0}) begin
      report_mismatch("dma_pkt_o.addr", 64'(dma_pkt_o.addr), 64'({addr[31:5], 5'b0}));
    end
    if (dma_pkt_o.mask !== (is_evict ? wmask : 8'h00)) begin
      report_mismatch("dma_pkt_o.mask", 64'(dma_pkt_o.mask), 64'(is_evict ? wmask : 8'h00));
    end
    if (dma_pkt_o.mshr_id !== id) begin
      report_mismatch("dma_pkt_o.mshr_id", 64'(dma_pkt_o.mshr_id), 64'(id));
    end
    if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
    @(posedge clk_i);
    dma_pkt_yumi_i <= 1'b1;
    @(negedge clk_i);
    if (mhu_dma_done_o !== onehot(id)) begin
      report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(onehot(id)));
    end
    // a nop must not raise valid or done even with yumi high
    @(posedge clk_i);
    cmd_i <= dma_nop;
    @(negedge clk_i);
    if (dma_pkt_v_o !== 1'b0) report_mismatch("dma_pkt_v_o", 64'(dma_pkt_v_o), 64'(0));
    if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
    @(posedge clk_i);
    dma_pkt_yumi_i <= 1'b0;
    end_test(name);
  endtask

  // hold keeps fill_ready_i low during intake
  // without hold the fill is gated by evict_enqueued_i
  task automatic refill_block(input string name, input logic hold);
    mshr_id_t id;
    burst_t bursts [`CDMA_BLOCK_BURSTS];
    burst_t exp_q [$];
    burst_t exp;
    logic cam_exp;
    int in_sent;
    int waits;
    int cam_cnt;
    int k;
    id = mshr_id_t'(rand_bits(2));
    mshr_copy = rand_block();
    mask_copy = block_mask_t'(rand_bits(32));
    for (k = 0; k < `CDMA_BLOCK_BURSTS; k++) begin
      bursts[k] = rand_bits(64);
      exp_q.push_back(merge_burst(bursts[k], k));
    end
    @(posedge clk_i);
    mshr_data_i <= mshr_copy;
    mshr_data_byte_mask_i <= mask_copy;
    // every other mshr looks enqueued so only the id bit may gate
    evict_enqueued_i <= hold ? onehot(id) : ~onehot(id);
    in_sent = 0;
    waits = 0;
    cam_cnt = 0;
    while (in_sent < `CDMA_BLOCK_BURSTS && waits < 100) begin
      @(posedge clk_i);
      dma_data_v_i <= rand_bit();
      dma_data_i <= bursts[in_sent];
      dma_refill_mshr_id_i <= (in_sent == 0) ? id : mshr_id_t'(rand_bits(2));
      fill_ready_i <= hold ? 1'b0 : rand_bit();
      @(negedge clk_i);
      if (!hold && fill_v_o !== 1'b0) begin
        report_problem("fill_v_o raised before the old line was enqueued");
      end
      // fewer than four bursts in, so memory data is always welcome
      if (dma_data_ready_o !== 1'b1) begin
        report_mismatch("dma_data_ready_o", 64'(dma_data_ready_o), 64'(1));
      end
      cam_exp = dma_data_v_i && (in_sent == 0);
      if (mshr_cam_r_v_o !== cam_exp) begin
        report_mismatch("mshr_cam_r_v_o", 64'(mshr_cam_r_v_o), 64'(cam_exp));
      end
      if (mshr_cam_r_v_o) cam_cnt++;
      if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
      if (dma_data_v_i && dma_data_ready_o) in_sent++;
      waits++;
    end
    if (in_sent < `CDMA_BLOCK_BURSTS) report_problem("timeout while sending refill bursts");
    if (cam_cnt != 1) report_problem("mshr_cam_r_v_o did not pulse exactly once");
    // a fifth burst is offered and must not be taken
    for (k = 0; k < 3; k++) begin
      @(posedge clk_i);
      dma_data_v_i <= 1'b1;
      dma_data_i <= rand_bits(64);
      @(negedge clk_i);
      if (dma_data_ready_o !== 1'b0) begin
        report_mismatch("dma_data_ready_o", 64'(dma_data_ready_o), 64'(0));
      end
    end
    waits = 0;
    while (exp_q.size() > 0 && waits < 200) begin
      @(posedge clk_i);
      dma_data_v_i <= 1'b0;
      evict_enqueued_i <= onehot(id);
      fill_ready_i <= rand_bit();
      @(negedge clk_i);
      if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
      if (fill_v_o && fill_ready_i) begin
        exp = exp_q.pop_front();
        if (fill_data_o !== exp) report_mismatch("fill_data_o", fill_data_o, exp);
        if (refill_mshr_id_o !== id) begin
          report_mismatch("refill_mshr_id_o", 64'(refill_mshr_id_o), 64'(id));
        end
      end
      waits++;
    end
    if (exp_q.size() > 0) report_problem("timeout while draining refill bursts");
    // refill done pulses with fill_done_i and then the path is idle again
    @(posedge clk_i);
    fill_ready_i <= 1'b0;
    fill_done_i <= 1'b1;
    @(negedge clk_i);
    if (fill_v_o !== 1'b0) report_problem("fill_v_o raised with no burst left");
    if (mhu_dma_done_o !== onehot(id)) begin
      report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(onehot(id)));
    end
    for (k = 0; k < 4; k++) begin
      @(posedge clk_i);
      fill_done_i <= 1'b0;
      @(negedge clk_i);
      if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
      if (dma_data_ready_o !== 1'b1) begin
        report_mismatch("dma_data_ready_o", 64'(dma_data_ready_o), 64'(1));
      end
    end
    end_test(name);
  endtask

  task automatic evict_block(input string name);
    mshr_id_t id;
    burst_t bursts [`CDMA_BLOCK_BURSTS];
    burst_t exp_q [$];
    burst_t exp;
    int taken;
    int waits;
    int k;
    id = mshr_id_t'(rand_bits(2));
    for (k = 0; k < `CDMA_BLOCK_BURSTS; k++) begin
      bursts[k] = rand_bits(64);
      exp_q.push_back(bursts[k]);
    end
    taken = 0;
    waits = 0;
    while (taken < `CDMA_BLOCK_BURSTS && waits < 100) begin
      @(posedge clk_i);
      evict_v_i <= rand_bit();
      evict_data_i <= bursts[taken];
      evict_mshr_id_i <= (taken == 0) ? id : mshr_id_t'(rand_bits(2));
      dma_data_yumi_i <= rand_bit();
      @(negedge clk_i);
      if (dma_data_v_o !== 1'b0) report_mismatch("dma_data_v_o", 64'(dma_data_v_o), 64'(0));
      if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
      // block not complete and buffer has room, so every offered burst is taken
      if (evict_yumi_o !== evict_v_i) begin
        report_mismatch("evict_yumi_o", 64'(evict_yumi_o), 64'(evict_v_i));
      end
      if (evict_v_i && evict_yumi_o) taken++;
      waits++;
    end
    if (taken < `CDMA_BLOCK_BURSTS) report_problem("timeout while collecting evict bursts");
    waits = 0;
    while (exp_q.size() > 0 && waits < 100) begin
      @(posedge clk_i);
      // extra evict data stays offered and must wait for the next block
      evict_v_i <= 1'b1;
      evict_data_i <= rand_bits(64);
      dma_data_yumi_i <= rand_bit();
      @(negedge clk_i);
      if (evict_yumi_o !== 1'b0) report_mismatch("evict_yumi_o", 64'(evict_yumi_o), 64'(0));
      if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
      if (dma_data_v_o && dma_data_yumi_i) begin
        exp = exp_q.pop_front();
        if (dma_data_o !== exp) report_mismatch("dma_data_o", dma_data_o, exp);
      end
      waits++;
    end
    if (exp_q.size() > 0) report_problem("timeout while draining evict bursts");
    @(posedge clk_i);
    evict_v_i <= 1'b0;
    dma_data_yumi_i <= 1'b0;
    @(negedge clk_i);
    if (mhu_dma_done_o !== onehot(id)) begin
      report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(onehot(id)));
    end
    @(negedge clk_i);
    if (mhu_dma_done_o !== '0) report_mismatch("mhu_dma_done_o", 64'(mhu_dma_done_o), 64'(0));
    if (dma_data_v_o !== 1'b0) report_mismatch("dma_data_v_o", 64'(dma_data_v_o), 64'(0));
    end_test(name);
  endtask

  initial begin
    lfsr_q = 16'd1453;
    err_cnt = 0;
    test_err_base = 0;
    tests_run = 0;
    tests_failed = 0;
    reset_i = 1'b1;
    cmd_i = dma_nop;
    req_addr_i = '0;
    req_mshr_id_i = '0;
    evict_word_mask_i = '0;
    dma_pkt_yumi_i = 1'b0;
    dma_data_i = '0;
    dma_refill_mshr_id_i = '0;
    dma_data_v_i = 1'b0;
    mshr_data_i = '0;
    mshr_data_byte_mask_i = '0;
    evict_enqueued_i = '0;
    fill_ready_i = 1'b0;
    fill_done_i = 1'b0;
    evict_data_i = '0;
    evict_v_i = 1'b0;
    evict_mshr_id_i = '0;
    dma_data_yumi_i = 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    check_reset();
    run_cmd(dma_send_refill_addr, "refill command");
    run_cmd(dma_send_evict_addr, "evict command");
    refill_block("refill merge and gating", 1'b0);
    refill_block("second refill block", 1'b0);
    evict_block("evict release");
    refill_block("refill back-pressure", 1'b1);
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
src/cache_geom_pkg.sv
src/dma_msg_pkg.sv
src/dma_done_if.sv
src/dma_burst_fifo.sv
src/dma_cmd_ctrl.sv
src/refill_path.sv
src/evict_path.sv
src/cache_dma.sv
verification/tb_cache_dma.sv

//--- run.sh
#!/bin/sh
# build the cache dma testbench with verilator, then run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_cache_dma -o tb_cache_dma || exit 1
# the run passes only if the testbench printed its pass line
out="$(./obj_dir/tb_cache_dma)"
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
